// ==== common/aer_pkg.sv ====
package aer_pkg;

    // Event word field widths
    localparam int EVT_ROW_W = 6;                 // Up to 64 rows
    localparam int EVT_COL_W = 6;                 // Up to 64 columns
    localparam int EVT_TS_W  = 18;                // Wall clock bits kept per event

    // Pixel request layout
    localparam int PIX_REQ_W  = 2;                // Bit 0 ON, bit 1 OFF
    localparam int PIX_ON_BIT = 0;                // ON bit decides polarity

    // One event, valid in the MSB
    typedef struct packed {
        logic                 valid;              // Set for a real event
        logic [EVT_ROW_W-1:0] row;                // Row address
        logic [EVT_COL_W-1:0] col;                // Column address
        logic                 polarity;           // 1 for ON
        logic [EVT_TS_W-1:0]  ts;                 // Timestamp
    } aer_event_t;

    // Same 32 bits seen as fields or as a bus word
    typedef union packed {
        aer_event_t  evt;                         // Written by the encoder
        logic [31:0] raw;                         // Returned to the host
    } aer_event_u;

    // AXI4-Lite host port
    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;

    typedef struct packed {
        logic                     aw_valid;
        logic [AXIL_ADDR_W-1:0]   aw_addr;
        logic                     w_valid;
        logic [AXIL_DATA_W-1:0]   w_data;
        logic [AXIL_DATA_W/8-1:0] w_strb;
        logic                     b_ready;
        logic                     ar_valid;
        logic [AXIL_ADDR_W-1:0]   ar_addr;
        logic                     r_ready;
    } axil_req_t;

    typedef struct packed {
        logic                   aw_ready;
        logic                   w_ready;
        logic                   b_valid;
        logic [1:0]             b_resp;
        logic                   ar_ready;
        logic                   r_valid;
        logic [AXIL_DATA_W-1:0] r_data;
        logic [1:0]             r_resp;
    } axil_rsp_t;

    localparam logic [1:0] AXIL_OKAY   = 2'b00;
    localparam logic [1:0] AXIL_SLVERR = 2'b10;

    // Register map
    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL   = 8'h00;  // Bit 0 scan enable
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 8'h04;  // FIFO fill count
    localparam logic [AXIL_ADDR_W-1:0] REG_EVENT  = 8'h08;  // Read pops one event

endpackage

// ==== arbiter/aer_rr_arbiter.sv ====
`timescale 1ns/1ps

module aer_rr_arbiter #(
    parameter int N = 8
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 advance_i,      // Move pointer past current winner
    input  logic [N-1:0]         req_i,
    output logic [N-1:0]         gnt_o,          // One-hot winner
    output logic [$clog2(N)-1:0] idx_o           // Winner index
);

    logic [$clog2(N)-1:0] ptr_q;                 // Highest priority position

    // Walk from the far end so the nearest request to the pointer wins
    always_comb
    begin
        int unsigned pos;
        gnt_o = '0;
        idx_o = '0;
        for (int i = N - 1; i >= 0; i--)
        begin
            pos = (int'(ptr_q) + i) % N;          // Offset i from the pointer
            if (req_i[pos])
                idx_o = pos[$clog2(N)-1:0];
        end
        gnt_o[idx_o] = |req_i;                   // No grant without a request
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            ptr_q <= '0;
        else if (advance_i && |req_i)
            ptr_q <= (int'(idx_o) == N - 1) ? '0 : idx_o + 1'b1;  // Wrap at the end
    end

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_o))
        else $error("Arbiter grant not one-hot");

endmodule

// ==== arbiter/aer_scan_ctrl.sv ====
`timescale 1ns/1ps

module aer_scan_ctrl #(
    parameter int ROWS = 8,
    parameter int COLS = 8
) (
    input  logic                                          clk_i,
    input  logic                                          reset_i,
    input  logic                                          scan_en_i,
    input  logic                                          fifo_full_i,    // Back-pressure
    input  logic [ROWS-1:0][COLS-1:0][aer_pkg::PIX_REQ_W-1:0] req_i,
    output logic [ROWS*COLS-1:0]                          gnt_o,          // Pixel grant pulse
    output logic                                          grant_valid_o,
    output logic [$clog2(ROWS)-1:0]                       grant_row_o,
    output logic [$clog2(COLS)-1:0]                       grant_col_o
);

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        ROW_SEL  = 2'd1,
        COL_SCAN = 2'd2
    } state_t;

    state_t                    state_q;
    logic [ROWS-1:0][COLS-1:0] pix_any;         // Any polarity requested
    logic [ROWS-1:0][COLS-1:0] live;            // Requests minus the pixel granted last cycle
    logic [ROWS-1:0]           row_req;
    logic [$clog2(ROWS)-1:0]   row_idx;
    logic [$clog2(ROWS)-1:0]   row_q;           // Row being scanned
    logic [COLS-1:0]           snap_q;          // Columns still owed a grant
    logic [COLS-1:0]           col_gnt;
    logic [$clog2(COLS)-1:0]   col_idx;
    logic                      row_adv;
    logic                      issue;           // Column grant decided this cycle

    always_comb
    begin
        for (int r = 0; r < ROWS; r++)
            for (int c = 0; c < COLS; c++)
                pix_any[r][c] = |req_i[r][c];
    end

    // Pixel sees its grant a cycle late, so its request may still be up at the next row pick
    assign live = pix_any & ~gnt_o;

    always_comb
    begin
        for (int r = 0; r < ROWS; r++)
            row_req[r] = |live[r];              // Row wants service
    end

    assign row_adv = (state_q == ROW_SEL) && scan_en_i && |row_req;
    assign issue   = (state_q == COL_SCAN) && scan_en_i && !fifo_full_i && |snap_q;

    aer_rr_arbiter #(.N(ROWS)) u_row_arb (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .advance_i (row_adv),
        .req_i     (row_req),
        .gnt_o     (),
        .idx_o     (row_idx)
    );

    aer_rr_arbiter #(.N(COLS)) u_col_arb (   // Pointer carries over between rows
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .advance_i (issue),
        .req_i     (snap_q),
        .gnt_o     (col_gnt),
        .idx_o     (col_idx)
    );

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q       <= IDLE;
            snap_q        <= '0;
            gnt_o         <= '0;
            grant_valid_o <= 1'b0;
        end
        else
        begin
            gnt_o         <= '0;                // Grants last one cycle
            grant_valid_o <= 1'b0;
            if (!scan_en_i)
                state_q <= IDLE;                // Disable wins in every state
            else
            begin
                case (state_q)
                    IDLE:     state_q <= ROW_SEL;
                    ROW_SEL:
                    begin
                        if (row_adv)
                        begin
                            snap_q  <= live[row_idx];   // Freeze this row's columns
                            state_q <= COL_SCAN;
                        end
                    end
                    COL_SCAN:
                    begin
                        if (issue)
                        begin
                            snap_q                            <= snap_q & ~col_gnt;
                            gnt_o[int'(row_q) * COLS + int'(col_idx)] <= 1'b1;
                            grant_valid_o                     <= 1'b1;
                        end
                        if ((snap_q & ~(issue ? col_gnt : '0)) == '0)
                            state_q <= ROW_SEL;         // Row done
                    end
                    default:  state_q <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (row_adv)
            row_q <= row_idx;
        if (issue)
        begin
            grant_row_o <= row_q;
            grant_col_o <= col_idx;
        end
    end

    a_pix_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_o))
        else $error("More than one pixel granted");

    a_no_gnt_full: assert property (@(posedge clk_i) disable iff (reset_i)
        fifo_full_i |=> !grant_valid_o)
        else $error("Grant issued while FIFO full");

endmodule

// ==== design/aer_event_encoder.sv ====
`timescale 1ns/1ps

module aer_event_encoder #(
    parameter int ROWS = 8,
    parameter int COLS = 8
) (
    input  logic                                          clk_i,
    input  logic                                          reset_i,
    input  logic                                          scan_en_i,      // Runs the wall clock
    input  logic                                          grant_valid_i,
    input  logic [$clog2(ROWS)-1:0]                       grant_row_i,
    input  logic [$clog2(COLS)-1:0]                       grant_col_i,
    input  logic [ROWS-1:0][COLS-1:0][aer_pkg::PIX_REQ_W-1:0] req_i,
    output logic                                          wr_en_o,
    output aer_pkg::aer_event_u                           wr_data_o
);

    import aer_pkg::*;

    logic [EVT_TS_W-1:0]  ts_q;                  // Free-running wall clock
    logic [PIX_REQ_W-1:0] pix_req;              // Granted pixel's live request

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            ts_q <= '0;
        else if (scan_en_i)
            ts_q <= ts_q + 1'b1;                // No wrap handling
    end

    assign pix_req = req_i[grant_row_i][grant_col_i];

    // FIFO takes the word on the edge that ends the grant cycle
    assign wr_en_o = grant_valid_i;

    always_comb
    begin
        wr_data_o.evt.valid    = 1'b1;
        wr_data_o.evt.row      = EVT_ROW_W'(grant_row_i);
        wr_data_o.evt.col      = EVT_COL_W'(grant_col_i);
        wr_data_o.evt.polarity = pix_req[PIX_ON_BIT];  // ON beats OFF when both set
        wr_data_o.evt.ts       = ts_q;
    end

    // Pixel keeps requesting through the cycle its grant is shown
    a_req_held: assert property (@(posedge clk_i) disable iff (reset_i)
        grant_valid_i |-> pix_req != '0)
        else $error("Granted pixel dropped its request too early");

endmodule

// ==== design/aer_event_fifo.sv ====
`timescale 1ns/1ps

module aer_event_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          wr_en_i,
    input  aer_pkg::aer_event_u           wr_data_i,
    input  logic                          rd_en_i,
    output aer_pkg::aer_event_u           rd_data_o,      // Head word, shown ahead of the pop
    output logic                          full_o,
    output logic                          empty_o,
    output logic [$clog2(FIFO_DEPTH):0]   count_o
);

    import aer_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    aer_event_u  mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (wr_en_i)
                wr_ptr_q <= wr_ptr_q + 1'b1;    // Depth is a power of two
            if (rd_en_i)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + (AW + 1)'(wr_en_i) - (AW + 1)'(rd_en_i);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (wr_en_i)
            mem[wr_ptr_q] <= wr_data_i;
    end

    assign rd_data_o = mem[rd_ptr_q];
    assign count_o   = count_q;
    assign empty_o   = (count_q == '0);
    // Also raised one entry early, since a write already in flight takes the last slot
    assign full_o    = (count_q == (AW + 1)'(FIFO_DEPTH)) ||
                       (count_q == (AW + 1)'(FIFO_DEPTH - 1) && wr_en_i && !rd_en_i);

    a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
        wr_en_i |-> count_q != (AW + 1)'(FIFO_DEPTH))
        else $error("Write into full FIFO");

    a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
        rd_en_i |-> count_q != '0)
        else $error("Read from empty FIFO");

endmodule

// ==== design/aer_axil_slave.sv ====
`timescale 1ns/1ps

module aer_axil_slave #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  aer_pkg::axil_req_t            axil_req_i,
    input  logic [$clog2(FIFO_DEPTH):0]   fifo_count_i,
    input  logic                          fifo_empty_i,
    input  aer_pkg::aer_event_u           fifo_data_i,
    output aer_pkg::axil_rsp_t            axil_rsp_o,
    output logic                          fifo_rd_o,      // Pop head event
    output logic                          scan_en_o
);

    import aer_pkg::*;

    logic                   aw_rdy_q;          // AW and W ready share one pulse
    logic                   ar_rdy_q;
    logic                   b_vld_q;
    logic                   r_vld_q;
    logic [1:0]             b_resp_q;
    logic [1:0]             r_resp_q;
    logic [AXIL_DATA_W-1:0] r_data_q;
    logic [AXIL_DATA_W-1:0] rd_word;           // Decoded read value
    logic                   rd_err;
    logic                   wr_err;
    logic                   wr_hs;
    logic                   rd_hs;

    assign wr_hs  = aw_rdy_q && axil_req_i.aw_valid && axil_req_i.w_valid;
    assign rd_hs  = ar_rdy_q && axil_req_i.ar_valid;
    assign wr_err = (axil_req_i.aw_addr != REG_CTRL);  // Only CTRL is writable

    always_comb
    begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (axil_req_i.ar_addr)
            REG_CTRL:   rd_word = AXIL_DATA_W'(scan_en_o);
            REG_STATUS: rd_word = AXIL_DATA_W'(fifo_count_i);
            REG_EVENT:  rd_word = fifo_empty_i ? '0 : fifo_data_i.raw;  // Empty reads as valid 0
            default:    rd_err  = 1'b1;
        endcase
    end

    assign fifo_rd_o = rd_hs && (axil_req_i.ar_addr == REG_EVENT) && !fifo_empty_i;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            aw_rdy_q  <= 1'b0;
            ar_rdy_q  <= 1'b0;
            b_vld_q   <= 1'b0;
            r_vld_q   <= 1'b0;
            scan_en_o <= 1'b0;
        end
        else
        begin
            // Single-cycle ready pulses, held off while a response is pending
            aw_rdy_q <= axil_req_i.aw_valid && axil_req_i.w_valid && !aw_rdy_q && !b_vld_q;
            ar_rdy_q <= axil_req_i.ar_valid && !ar_rdy_q && !r_vld_q;
            if (wr_hs)
                b_vld_q <= 1'b1;
            else if (axil_req_i.b_ready)
                b_vld_q <= 1'b0;
            if (rd_hs)
                r_vld_q <= 1'b1;
            else if (axil_req_i.r_ready)
                r_vld_q <= 1'b0;
            if (wr_hs && !wr_err && axil_req_i.w_strb[0])
                scan_en_o <= axil_req_i.w_data[0];
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (wr_hs)
            b_resp_q <= wr_err ? AXIL_SLVERR : AXIL_OKAY;
        if (rd_hs)
        begin
            r_data_q <= rd_word;               // Popped event latched here
            r_resp_q <= rd_err ? AXIL_SLVERR : AXIL_OKAY;
        end
    end

    always_comb
    begin
        axil_rsp_o.aw_ready = aw_rdy_q;
        axil_rsp_o.w_ready  = aw_rdy_q;
        axil_rsp_o.b_valid  = b_vld_q;
        axil_rsp_o.b_resp   = b_resp_q;
        axil_rsp_o.ar_ready = ar_rdy_q;
        axil_rsp_o.r_valid  = r_vld_q;
        axil_rsp_o.r_data   = r_data_q;
        axil_rsp_o.r_resp   = r_resp_q;
    end

endmodule

// ==== design/aer_top.sv ====
`timescale 1ns/1ps

module aer_top #(
    parameter int ROWS       = 8,
    parameter int COLS       = 8,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                                          clk_i,
    input  logic                                          reset_i,
    input  logic [ROWS-1:0][COLS-1:0][aer_pkg::PIX_REQ_W-1:0] req_i,
    input  aer_pkg::axil_req_t                            axil_req_i,
    output logic [ROWS*COLS-1:0]                          gnt_o,          // Bit row*COLS+col
    output aer_pkg::axil_rsp_t                            axil_rsp_o
);

    import aer_pkg::*;

    logic                          scan_en;
    logic                          grant_valid;
    logic [$clog2(ROWS)-1:0]       grant_row;
    logic [$clog2(COLS)-1:0]       grant_col;
    logic                          wr_en;
    aer_event_u                    wr_data;
    logic                          rd_en;
    aer_event_u                    rd_data;
    logic                          full;
    logic                          empty;
    logic [$clog2(FIFO_DEPTH):0]   count;

    // Input side
    aer_scan_ctrl #(.ROWS(ROWS), .COLS(COLS)) u_scan (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .scan_en_i     (scan_en),
        .fifo_full_i   (full),
        .req_i         (req_i),
        .gnt_o         (gnt_o),
        .grant_valid_o (grant_valid),
        .grant_row_o   (grant_row),
        .grant_col_o   (grant_col)
    );

    // Processing part
    aer_event_encoder #(.ROWS(ROWS), .COLS(COLS)) u_enc (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .scan_en_i     (scan_en),
        .grant_valid_i (grant_valid),
        .grant_row_i   (grant_row),
        .grant_col_i   (grant_col),
        .req_i         (req_i),
        .wr_en_o       (wr_en),
        .wr_data_o     (wr_data)
    );

    // Output side
    aer_event_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wr_en_i   (wr_en),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_data_o (rd_data),
        .full_o    (full),
        .empty_o   (empty),
        .count_o   (count)
    );

    aer_axil_slave #(.FIFO_DEPTH(FIFO_DEPTH)) u_axil (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .axil_req_i   (axil_req_i),
        .fifo_count_i (count),
        .fifo_empty_i (empty),
        .fifo_data_i  (rd_data),
        .axil_rsp_o   (axil_rsp_o),
        .fifo_rd_o    (rd_en),
        .scan_en_o    (scan_en)
    );

endmodule

// ==== tests/aer_tb_check.svh ====
`ifndef AER_TB_CHECK_SVH
`define AER_TB_CHECK_SVH

// Counts one failed check against the run and the current test
task automatic note_error();
    err_count++;
    test_errs++;
endtask

// Compares address and polarity fields since the timestamp is not predicted
task automatic check_event(input string what, input aer_event_t exp, input aer_event_t act);
    if (act.valid !== exp.valid || act.row !== exp.row || act.col !== exp.col ||
        act.polarity !== exp.polarity)
    begin
        $display("ERROR %s %s: expected row %0d col %0d pol %0d, actual row %0d col %0d pol %0d",
                 cur_test, what, exp.row, exp.col, exp.polarity, act.row, act.col, act.polarity);
        note_error();
    end
endtask

task automatic check_word(input string what, input logic [AXIL_DATA_W-1:0] exp,
                          input logic [AXIL_DATA_W-1:0] act);
    if (act !== exp)
    begin
        $display("ERROR %s %s: expected %h actual %h", cur_test, what, exp, act);
        note_error();
    end
endtask

task automatic check_resp(input string what, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp)
    begin
        $display("ERROR %s %s: expected resp %b actual resp %b", cur_test, what, exp, act);
        note_error();
    end
endtask

// Single write with AW and W together
task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr,
                          input logic [AXIL_DATA_W-1:0] data, output logic [1:0] resp);
    @(negedge clk_i);
    axil_req.aw_valid = 1'b1;
    axil_req.aw_addr  = addr;
    axil_req.w_valid  = 1'b1;
    axil_req.w_data   = data;
    axil_req.w_strb   = '1;
    do
        @(negedge clk_i);
    while (!axil_rsp.aw_ready && !axil_rsp.w_ready);  // Handshake on the coming rising edge
    if (axil_rsp.aw_ready !== 1'b1 || axil_rsp.w_ready !== 1'b1)
    begin
        $display("%s: AW ready and W ready did not pulse together", cur_test);
        note_error();
    end
    @(negedge clk_i);
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    axil_req.b_ready  = 1'b1;
    while (!axil_rsp.b_valid)
        @(negedge clk_i);
    resp = axil_rsp.b_resp;
    @(negedge clk_i);
    axil_req.b_ready = 1'b0;
endtask

task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr,
                         output logic [AXIL_DATA_W-1:0] data, output logic [1:0] resp);
    @(negedge clk_i);
    axil_req.ar_valid = 1'b1;
    axil_req.ar_addr  = addr;
    do
        @(negedge clk_i);
    while (!axil_rsp.ar_ready);
    @(negedge clk_i);
    axil_req.ar_valid = 1'b0;
    axil_req.r_ready  = 1'b1;
    while (!axil_rsp.r_valid)
        @(negedge clk_i);
    data = axil_rsp.r_data;                      // Held until R ready is seen
    resp = axil_rsp.r_resp;
    @(negedge clk_i);
    axil_req.r_ready = 1'b0;
endtask

`endif

// ==== tests/aer_tb.sv ====
`timescale 1ns/1ps

module aer_tb;

    import aer_pkg::*;

    localparam int ROWS       = 8;
    localparam int COLS       = 8;
    localparam int FIFO_DEPTH = 16;
    localparam int NUM_TESTS  = 6;

    typedef logic [ROWS-1:0][COLS-1:0][PIX_REQ_W-1:0] pix_arr_t;

    logic                 clk_i;
    logic                 reset_i;
    pix_arr_t             pix_req;                // Live pixel requests
    pix_arr_t             batch;                  // Requests of the current test
    logic [ROWS*COLS-1:0] gnt;
    logic [ROWS*COLS-1:0] gnt_seen;               // Grants seen on the last falling edge
    axil_req_t            axil_req;
    axil_rsp_t            axil_rsp;
    integer               seed;
    int                   err_count;
    int                   test_errs;
    int                   tests_run;
    int                   tests_failed;
    int                   grant_count;            // Pixel grants since reset
    int                   model_row;              // Reference row pointer
    int                   model_col;              // Reference column pointer
    string                cur_test;
    aer_event_t           exp_q[$];
    aer_event_t           got_q[$];

    `include "aer_tb_check.svh"

    aer_top #(.ROWS(ROWS), .COLS(COLS), .FIFO_DEPTH(FIFO_DEPTH)) DUT (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .req_i      (pix_req),
        .axil_req_i (axil_req),
        .gnt_o      (gnt),
        .axil_rsp_o (axil_rsp)
    );

    initial
    begin
        clk_i = 1'b0;
        forever
            #5 clk_i = ~clk_i;
    end

    // Pixel model drops the request one falling edge after its grant is seen
    always @(negedge clk_i)
    begin
        for (int i = 0; i < ROWS * COLS; i++)
            if (gnt_seen[i])
                pix_req[i / COLS][i % COLS] = '0;
        grant_count += $countones(gnt);
        gnt_seen = gnt;
    end

    // Expected grant order is row round-robin and then the row's columns round-robin
    function automatic void predict_events(input pix_arr_t reqs);
        logic [ROWS-1:0][COLS-1:0] pending;
        logic [COLS-1:0]           snap;
        aer_event_t                ev;
        int                        r;
        int                        c;
        exp_q.delete();
        for (int rr = 0; rr < ROWS; rr++)
            for (int cc = 0; cc < COLS; cc++)
                pending[rr][cc] = |reqs[rr][cc];
        while (pending != '0)
        begin
            r = model_row;
            while (pending[r] == '0)
                r = (r + 1) % ROWS;
            model_row = (r + 1) % ROWS;
            snap      = pending[r];               // Row frozen when picked
            while (snap != '0)
            begin
                c = model_col;
                while (!snap[c])
                    c = (c + 1) % COLS;
                model_col     = (c + 1) % COLS;   // Column pointer survives the row change
                snap[c]       = 1'b0;
                pending[r][c] = 1'b0;
                ev            = '0;
                ev.valid      = 1'b1;
                ev.row        = EVT_ROW_W'(r);
                ev.col        = EVT_COL_W'(c);
                ev.polarity   = reqs[r][c][0];    // ON bit set means ON
                exp_q.push_back(ev);
            end
        end
    endfunction

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs != 0)
            tests_failed++;
        $display("%s: %s", cur_test, (test_errs == 0) ? "passed" : "failed");
    endtask

    // Distinct random pixels with ON, OFF or both
    task automatic make_batch(input int n);
        int r;
        int c;
        batch = '0;
        for (int k = 0; k < n; k++)
        begin
            do
            begin
                r = $unsigned($random(seed)) % ROWS;
                c = $unsigned($random(seed)) % COLS;
            end
            while (batch[r][c] != '0);
            batch[r][c] = 2'($unsigned($random(seed)) % 3 + 1);
        end
    endtask

    task automatic apply_batch();
        @(negedge clk_i);
        pix_req = pix_req | batch;                // All pixels raise together
    endtask

    // Pops REG_EVENT until n real events arrive and skips empty reads
    task automatic collect_events(input int n);
        logic [AXIL_DATA_W-1:0] data;
        logic [1:0]             resp;
        aer_event_u             word;
        int                     tries;
        got_q.delete();
        tries = 0;
        while (got_q.size() < n && tries < n * 40)
        begin
            axil_read(REG_EVENT, data, resp);
            check_resp("event read", AXIL_OKAY, resp);
            word.raw = data;
            if (word.evt.valid)
                got_q.push_back(word.evt);
            tries++;
        end
        if (got_q.size() != n)
        begin
            $display("%s: only %0d of %0d events arrived", cur_test, got_q.size(), n);
            note_error();
        end
    endtask

    task automatic check_ts_rising();
        for (int i = 1; i < got_q.size(); i++)
            if (got_q[i].ts <= got_q[i-1].ts)
            begin
                $display("%s: timestamp did not increase at event %0d", cur_test, i);
                note_error();
            end
    endtask

    task automatic compare_order();
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++)
            check_event($sformatf("event %0d", i), exp_q[i], got_q[i]);
        check_ts_rising();
    endtask

    // Order is free here but each pixel must appear once
    task automatic compare_set();
        int hits;
        foreach (exp_q[i])
        begin
            hits = 0;
            foreach (got_q[j])
                if (got_q[j].row == exp_q[i].row && got_q[j].col == exp_q[i].col)
                begin
                    hits++;
                    check_event("event", exp_q[i], got_q[j]);
                end
            if (hits != 1)
            begin
                $display("%s: pixel %0d,%0d gave %0d events", cur_test, exp_q[i].row,
                         exp_q[i].col, hits);
                note_error();
            end
        end
        check_ts_rising();
    endtask

    // No extra event may follow the batch
    task automatic expect_drained();
        logic [AXIL_DATA_W-1:0] data;
        logic [1:0]             resp;
        repeat (20) @(negedge clk_i);
        axil_read(REG_STATUS, data, resp);
        check_word("fill count after batch", '0, data);
    endtask

    initial
    begin
        logic [AXIL_DATA_W-1:0] data;
        logic [1:0]             resp;
        int                     base;
        int                     mid;
        seed         = 32'hf9f8;
        reset_i      = 1'b1;
        pix_req      = '0;
        batch        = '0;
        axil_req     = '0;
        gnt_seen     = '0;
        err_count    = 0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        grant_count  = 0;
        model_row    = 0;
        model_col    = 0;
        repeat (5) @(negedge clk_i);
        reset_i = 1'b0;

        start_test("reset values");
        axil_read(REG_CTRL, data, resp);
        check_word("ctrl", '0, data);
        axil_read(REG_STATUS, data, resp);
        check_word("status", '0, data);
        axil_read(REG_EVENT, data, resp);
        check_word("event when empty", '0, data);
        check_resp("event when empty", AXIL_OKAY, resp);
        @(negedge clk_i);
        pix_req[3][5] = 2'b01;
        repeat (50)
        begin
            @(negedge clk_i);
            if (gnt !== '0)
            begin
                $display("%s: pixel granted while scan is disabled", cur_test);
                note_error();
            end
        end
        pix_req = '0;
        end_test();

        start_test("single pixel");
        axil_write(REG_CTRL, 32'h1, resp);
        check_resp("enable write", AXIL_OKAY, resp);
        for (int k = 0; k < 2; k++)
        begin
            batch = '0;
            batch[2 + k][6 - k] = (k == 0) ? 2'b10 : 2'b11;  // OFF alone, then both bits
            apply_batch();
            predict_events(batch);
            collect_events(1);
            compare_order();
            expect_drained();
        end
        end_test();

        start_test("random batch");
        make_batch(1 + $unsigned($random(seed)) % 16);
        apply_batch();
        predict_events(batch);
        collect_events(exp_q.size());
        compare_order();
        expect_drained();
        end_test();

        start_test("back-pressure");
        make_batch(24);
        @(posedge clk_i);
        base = grant_count;
        apply_batch();
        predict_events(batch);
        wait (grant_count - base >= FIFO_DEPTH);
        repeat (30) @(negedge clk_i);
        @(posedge clk_i);
        check_word("grants with FIFO full", FIFO_DEPTH, grant_count - base);
        axil_read(REG_STATUS, data, resp);
        check_word("status when full", FIFO_DEPTH, data);
        collect_events(exp_q.size());
        compare_order();
        expect_drained();
        end_test();

        start_test("error responses");
        axil_write(REG_STATUS, 32'h0, resp);
        check_resp("status write", AXIL_SLVERR, resp);
        axil_read(8'h0c, data, resp);
        check_resp("unmapped read", AXIL_SLVERR, resp);
        axil_write(8'h10, 32'h0, resp);
        check_resp("unmapped write", AXIL_SLVERR, resp);
        axil_read(REG_CTRL, data, resp);
        check_word("ctrl kept", 32'h1, data);
        axil_read(REG_STATUS, data, resp);
        check_word("status kept", '0, data);
        end_test();

        start_test("pause and resume");
        make_batch(12);
        @(posedge clk_i);
        base = grant_count;
        apply_batch();
        predict_events(batch);
        wait (grant_count - base >= 5);
        axil_write(REG_CTRL, 32'h0, resp);
        repeat (3) @(negedge clk_i);
        @(posedge clk_i);
        mid = grant_count;                        // Grants in flight have landed
        repeat (30) @(negedge clk_i);
        @(posedge clk_i);
        check_word("grants while paused", mid, grant_count);
        axil_write(REG_CTRL, 32'h1, resp);
        collect_events(exp_q.size());
        compare_set();
        expect_drained();
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // Budget of 2000 cycles per test
    initial
    begin
        repeat (NUM_TESTS * 2000) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles, run stopped in %s", NUM_TESTS * 2000,
                 cur_test);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+tests
common/aer_pkg.sv
arbiter/aer_rr_arbiter.sv
arbiter/aer_scan_ctrl.sv
design/aer_event_encoder.sv
design/aer_event_fifo.sv
design/aer_axil_slave.sv
design/aer_top.sv
tests/aer_tb.sv

// ==== Bender.yml ====
package:
  name: aer_readout

sources:
  - common/aer_pkg.sv
  - arbiter/aer_rr_arbiter.sv
  - arbiter/aer_scan_ctrl.sv
  - design/aer_event_encoder.sv
  - design/aer_event_fifo.sv
  - design/aer_axil_slave.sv
  - design/aer_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/aer_tb.sv
